// File: src/uart_cfg_pkg.sv
package uart_cfg_pkg;

	typedef logic [7:0]  uart_data_t;
	typedef logic [1:0]  uart_len_t;
	typedef logic [15:0] uart_div_t;
	typedef logic [3:0]  uart_tick_t;

	// character length is the selector plus this
	localparam int LEN_BASE = 5;

	// 16 ticks per bit, counted 0..15
	localparam uart_tick_t TICK_LAST = 4'd15;
	// start bit confirmed half a bit after detection
	localparam uart_tick_t TICK_MID = 4'd8;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP1,
		TX_STOP2
	} tx_state_t;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP1,
		RX_STOP2,
		RX_HOLD
	} rx_state_t;

	// index of the last data bit for a length selector
	function automatic logic [2:0] last_bit(input uart_len_t len);
		return 3'(len) + 3'(LEN_BASE - 1);
	endfunction

endpackage

// File: src/uart_stat_pkg.sv
package uart_stat_pkg;

	typedef logic [15:0] uart_count_t;
	typedef logic [2:0]  uart_err_t;

	// bit positions in uart_err_t
	localparam int ERR_PAR   = 0;
	localparam int ERR_STOP1 = 1;
	localparam int ERR_STOP2 = 2;

	// slots of the statistics counter array
	localparam int STAT_TX      = 0;
	localparam int STAT_RX      = 1;
	localparam int STAT_PAR     = 2;
	localparam int STAT_STOP    = 3;
	localparam int STAT_OVERRUN = 4;
	localparam int NUM_STATS    = 5;

endpackage

// File: src/uart_baud_gen.sv
`timescale 1ns/10ps

module uart_baud_gen #(
	parameter int DIVISOR_W = $bits(uart_cfg_pkg::uart_div_t)
) (
	input  logic                 test_tx_clk,
	input  logic                 arst_n,
	input  logic [DIVISOR_W-1:0] divisor,
	output logic                 tick16
);

	logic [DIVISOR_W-1:0] cnt;

	// one tick every divisor+1 clocks
	always_ff @(posedge test_tx_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt    <= '0;
			tick16 <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt    <= divisor;
			tick16 <= 1'b1;
		end
		else
		begin
			cnt    <= cnt - 1'b1;
			tick16 <= 1'b0;
		end
	end

endmodule

// File: src/uart_tx_frame.sv
`timescale 1ns/10ps

module uart_tx_frame (
	input  logic                     test_tx_clk,
	input  logic                     arst_n,
	input  logic                     tick16,
	input  uart_cfg_pkg::uart_len_t  data_len,
	input  logic                     two_stop,
	input  logic                     parity_en,
	input  logic                     even_parity,
	input  uart_cfg_pkg::uart_data_t tx_data,
	input  logic                     tx_valid,
	output logic                     tx_ready,
	output logic                     sout,
	output logic                     tx_done
);
	import uart_cfg_pkg::*;

	tx_state_t  state;
	uart_tick_t tick_cnt;
	logic [2:0] bit_cnt;
	uart_data_t shreg;
	logic       par_acc;
	logic       pending;
	logic       bit_end;
	logic       par_next;

	assign tx_ready = (state == TX_IDLE);
	assign bit_end  = tick16 && !pending && (tick_cnt == TICK_LAST);
	// parity including the bit now on the line
	assign par_next = par_acc ^ shreg[0];

	//////////////////////////////
	// frame sequencer
	//////////////////////////////
	always_ff @(posedge test_tx_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= TX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			par_acc  <= 1'b0;
			pending  <= 1'b0;
			sout     <= 1'b1;
			tx_done  <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			// 4-bit count wraps to 0 at each bit boundary
			if (tick16 && !pending && state != TX_IDLE)
				tick_cnt <= tick_cnt + 1'b1;
			case (state)
				TX_IDLE:
					if (tx_valid)
					begin
						state   <= TX_START;
						pending <= 1'b1;
						par_acc <= 1'b0;
						bit_cnt <= '0;
					end
				TX_START:
					if (pending && tick16)
					begin
						// start bit goes out on the first tick after accept
						pending  <= 1'b0;
						tick_cnt <= '0;
						sout     <= 1'b0;
					end
					else if (bit_end)
					begin
						state <= TX_DATA;
						sout  <= shreg[0];
					end
				TX_DATA:
					if (bit_end)
					begin
						par_acc <= par_next;
						if (bit_cnt == last_bit(data_len))
						begin
							if (parity_en)
							begin
								state <= TX_PARITY;
								sout  <= even_parity ? par_next : ~par_next;
							end
							else
							begin
								state <= TX_STOP1;
								sout  <= 1'b1;
							end
						end
						else
						begin
							bit_cnt <= bit_cnt + 1'b1;
							sout    <= shreg[1];
						end
					end
				TX_PARITY:
					if (bit_end)
					begin
						state <= TX_STOP1;
						sout  <= 1'b1;
					end
				TX_STOP1:
					if (bit_end)
					begin
						if (two_stop)
							state <= TX_STOP2;
						else
						begin
							state   <= TX_IDLE;
							tx_done <= 1'b1;
						end
					end
				TX_STOP2:
					if (bit_end)
					begin
						state   <= TX_IDLE;
						tx_done <= 1'b1;
					end
				default:
					state <= TX_IDLE;
			endcase
		end
	end

	// byte latch, shifted LSB first
	always_ff @(posedge test_tx_clk)
	begin
		if (tx_ready && tx_valid)
			shreg <= tx_data;
		else if (state == TX_DATA && bit_end)
			shreg <= shreg >> 1;
	end

endmodule

// File: src/uart_rx_frame.sv
`timescale 1ns/10ps

module uart_rx_frame (
	input  logic                     test_tx_clk,
	input  logic                     arst_n,
	input  logic                     tick16,
	input  uart_cfg_pkg::uart_len_t  data_len,
	input  logic                     two_stop,
	input  logic                     parity_en,
	input  logic                     even_parity,
	input  logic                     sin,
	output uart_cfg_pkg::uart_data_t rx_data,
	output uart_stat_pkg::uart_err_t rx_err,
	output logic                     rx_valid,
	input  logic                     rx_ready,
	output logic                     rx_done,
	output logic                     rx_overrun
);
	import uart_cfg_pkg::*;
	import uart_stat_pkg::*;

	// right shift that moves a short character down to bit 0
	localparam logic [2:0] ALIGN_MAX = 3'($bits(uart_data_t) - LEN_BASE);

	logic       sin_meta;
	logic       sin_s;
	rx_state_t  state;
	uart_tick_t tick_cnt;
	logic [2:0] bit_cnt;
	uart_data_t shreg;
	logic       par_acc;
	uart_err_t  err_acc;
	logic       sample;
	logic       frame_end;
	logic       blocked;
	logic [2:0] align_sh;

	assign sample   = tick16 && (tick_cnt == TICK_LAST);
	assign blocked  = rx_valid && !rx_ready;
	assign align_sh = ALIGN_MAX - 3'(data_len);

	// two-flop synchronizer, idles high
	always_ff @(posedge test_tx_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sin_meta <= 1'b1;
			sin_s    <= 1'b1;
		end
		else
		begin
			sin_meta <= sin;
			sin_s    <= sin_meta;
		end
	end

	//////////////////////////////
	// frame sequencer
	//////////////////////////////
	always_ff @(posedge test_tx_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state     <= RX_IDLE;
			tick_cnt  <= '0;
			bit_cnt   <= '0;
			par_acc   <= 1'b0;
			err_acc   <= '0;
			frame_end <= 1'b0;
		end
		else
		begin
			frame_end <= 1'b0;
			if (tick16 && state != RX_IDLE && state != RX_HOLD)
				tick_cnt <= tick_cnt + 1'b1;
			case (state)
				RX_IDLE:
					if (tick16 && !sin_s)
					begin
						state    <= RX_START;
						tick_cnt <= '0;
					end
				RX_START:
					if (tick16 && tick_cnt == TICK_MID)
					begin
						// line back high at mid-bit means a glitch
						if (sin_s)
							state <= RX_IDLE;
						else
						begin
							state    <= RX_DATA;
							tick_cnt <= '0;
							bit_cnt  <= '0;
							par_acc  <= 1'b0;
							err_acc  <= '0;
						end
					end
				RX_DATA:
					if (sample)
					begin
						par_acc <= par_acc ^ sin_s;
						if (bit_cnt == last_bit(data_len))
							state <= parity_en ? RX_PARITY : RX_STOP1;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
				RX_PARITY:
					if (sample)
					begin
						if (sin_s != (even_parity ? par_acc : ~par_acc))
							err_acc[ERR_PAR] <= 1'b1;
						state <= RX_STOP1;
					end
				RX_STOP1:
					if (sample)
					begin
						if (!sin_s)
							err_acc[ERR_STOP1] <= 1'b1;
						if (two_stop)
							state <= RX_STOP2;
						else
						begin
							state     <= RX_HOLD;
							frame_end <= 1'b1;
						end
					end
				RX_STOP2:
					if (sample)
					begin
						if (!sin_s)
							err_acc[ERR_STOP2] <= 1'b1;
						state     <= RX_HOLD;
						frame_end <= 1'b1;
					end
				RX_HOLD:
					// a low stop bit must clear before the next start search
					if (sin_s)
						state <= RX_IDLE;
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// data enters at the top, first bit ends lowest
	always_ff @(posedge test_tx_clk)
	begin
		if (state == RX_DATA && sample)
			shreg <= {sin_s, shreg[7:1]};
	end

	//////////////////////////////
	// output handshake
	//////////////////////////////
	always_ff @(posedge test_tx_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rx_valid   <= 1'b0;
			rx_done    <= 1'b0;
			rx_overrun <= 1'b0;
		end
		else
		begin
			rx_done    <= frame_end;
			rx_overrun <= frame_end && blocked;
			if (frame_end && !blocked)
				rx_valid <= 1'b1;
			else if (rx_ready)
				rx_valid <= 1'b0;
		end
	end

	// held frame stays put on overrun
	always_ff @(posedge test_tx_clk)
	begin
		if (frame_end && !blocked)
		begin
			rx_data <= shreg >> align_sh;
			rx_err  <= err_acc;
		end
	end

endmodule

// File: src/uart_line_stats.sv
`timescale 1ns/10ps

module uart_line_stats #(
	parameter int COUNT_W = $bits(uart_stat_pkg::uart_count_t)
) (
	input  logic                     test_tx_clk,
	input  logic                     arst_n,
	input  logic                     stats_clear,
	input  logic                     tx_done,
	input  logic                     rx_valid,
	input  logic                     rx_ready,
	input  uart_stat_pkg::uart_err_t rx_err,
	input  logic                     rx_overrun,
	output logic [COUNT_W-1:0]       tx_count,
	output logic [COUNT_W-1:0]       rx_count,
	output logic [COUNT_W-1:0]       par_err_count,
	output logic [COUNT_W-1:0]       stop_err_count,
	output logic [COUNT_W-1:0]       overrun_count
);
	import uart_stat_pkg::*;

	logic                 rx_fire;
	logic [NUM_STATS-1:0] ev;
	logic [COUNT_W-1:0]   cnt [NUM_STATS];

	// received frames count only when delivered
	assign rx_fire = rx_valid && rx_ready;

	assign ev[STAT_TX]      = tx_done;
	assign ev[STAT_RX]      = rx_fire;
	assign ev[STAT_PAR]     = rx_fire && rx_err[ERR_PAR];
	// one count per frame even with both stop flags
	assign ev[STAT_STOP]    = rx_fire && (rx_err[ERR_STOP1] || rx_err[ERR_STOP2]);
	assign ev[STAT_OVERRUN] = rx_overrun;

	//////////////////////////////
	// saturating counters
	//////////////////////////////
	always_ff @(posedge test_tx_clk or negedge arst_n)
	begin
		if (!arst_n)
			cnt <= '{default: '0};
		else if (stats_clear)
			cnt <= '{default: '0};
		else
		begin
			for (int i = 0; i < NUM_STATS; i++)
			begin
				if (ev[i] && !(&cnt[i]))
					cnt[i] <= cnt[i] + 1'b1;
			end
		end
	end

	assign tx_count       = cnt[STAT_TX];
	assign rx_count       = cnt[STAT_RX];
	assign par_err_count  = cnt[STAT_PAR];
	assign stop_err_count = cnt[STAT_STOP];
	assign overrun_count  = cnt[STAT_OVERRUN];

endmodule

// File: src/uart_subsys_top.sv
`timescale 1ns/10ps

module uart_subsys_top #(
	parameter int DIVISOR_W = $bits(uart_cfg_pkg::uart_div_t),
	parameter int COUNT_W   = $bits(uart_stat_pkg::uart_count_t)
) (
	input  logic                     test_tx_clk,
	input  logic                     arst_n,
	input  uart_cfg_pkg::uart_len_t  data_len,
	input  logic                     two_stop,
	input  logic                     parity_en,
	input  logic                     even_parity,
	input  logic [DIVISOR_W-1:0]     divisor,
	input  uart_cfg_pkg::uart_data_t tx_data,
	input  logic                     tx_valid,
	output logic                     tx_ready,
	output logic                     sout,
	input  logic                     sin,
	output uart_cfg_pkg::uart_data_t rx_data,
	output uart_stat_pkg::uart_err_t rx_err,
	output logic                     rx_valid,
	input  logic                     rx_ready,
	input  logic                     stats_clear,
	output logic [COUNT_W-1:0]       tx_count,
	output logic [COUNT_W-1:0]       rx_count,
	output logic [COUNT_W-1:0]       par_err_count,
	output logic [COUNT_W-1:0]       stop_err_count,
	output logic [COUNT_W-1:0]       overrun_count
);

	logic tick16;
	logic tx_done;
	// observed by the bound checker only
	logic rx_done;
	logic rx_overrun;

	uart_baud_gen #(
		.DIVISOR_W (DIVISOR_W)
	) uart_baud_gen_i (
		.test_tx_clk (test_tx_clk),
		.arst_n      (arst_n),
		.divisor     (divisor),
		.tick16      (tick16)
	);

	uart_tx_frame uart_tx_frame_i (
		.test_tx_clk (test_tx_clk),
		.arst_n      (arst_n),
		.tick16      (tick16),
		.data_len    (data_len),
		.two_stop    (two_stop),
		.parity_en   (parity_en),
		.even_parity (even_parity),
		.tx_data     (tx_data),
		.tx_valid    (tx_valid),
		.tx_ready    (tx_ready),
		.sout        (sout),
		.tx_done     (tx_done)
	);

	uart_rx_frame uart_rx_frame_i (
		.test_tx_clk (test_tx_clk),
		.arst_n      (arst_n),
		.tick16      (tick16),
		.data_len    (data_len),
		.two_stop    (two_stop),
		.parity_en   (parity_en),
		.even_parity (even_parity),
		.sin         (sin),
		.rx_data     (rx_data),
		.rx_err      (rx_err),
		.rx_valid    (rx_valid),
		.rx_ready    (rx_ready),
		.rx_done     (rx_done),
		.rx_overrun  (rx_overrun)
	);

	uart_line_stats #(
		.COUNT_W (COUNT_W)
	) uart_line_stats_i (
		.test_tx_clk    (test_tx_clk),
		.arst_n         (arst_n),
		.stats_clear    (stats_clear),
		.tx_done        (tx_done),
		.rx_valid       (rx_valid),
		.rx_ready       (rx_ready),
		.rx_err         (rx_err),
		.rx_overrun     (rx_overrun),
		.tx_count       (tx_count),
		.rx_count       (rx_count),
		.par_err_count  (par_err_count),
		.stop_err_count (stop_err_count),
		.overrun_count  (overrun_count)
	);

endmodule

// File: testbench/uart_subsys_chk.sv
`timescale 1ns/10ps

module uart_subsys_chk (
	input logic                     test_tx_clk,
	input logic                     arst_n,
	input uart_cfg_pkg::uart_data_t tx_data,
	input logic                     tx_valid,
	input logic                     tx_ready,
	input logic                     sout,
	input uart_cfg_pkg::uart_data_t rx_data,
	input logic                     rx_valid,
	input logic                     rx_ready,
	input logic                     rx_done
);

	// source holds the byte until the transmitter takes it
	tx_data_held: assert property (@(posedge test_tx_clk) disable iff (!arst_n)
		tx_valid && !tx_ready |=> $stable(tx_data))
		else $error("tx_data changed while tx_valid waited for tx_ready");

	rx_valid_held: assert property (@(posedge test_tx_clk) disable iff (!arst_n)
		rx_valid && !rx_ready |=> rx_valid)
		else $error("rx_valid dropped before rx_ready");

	// an overrun keeps the held character
	rx_data_held: assert property (@(posedge test_tx_clk) disable iff (!arst_n)
		rx_valid && !rx_ready |=> $stable(rx_data))
		else $error("rx_data changed while waiting for rx_ready");

	// one pulse per completed frame
	rx_done_pulse: assert property (@(posedge test_tx_clk) disable iff (!arst_n)
		rx_done |=> !rx_done)
		else $error("rx_done stayed high for more than one cycle");

	reset_levels: assert property (@(posedge test_tx_clk)
		!arst_n |=> sout && !rx_valid)
		else $error("sout or rx_valid not at reset level after reset");

endmodule

bind uart_subsys_top uart_subsys_chk uart_subsys_chk_i (
	.test_tx_clk (test_tx_clk),
	.arst_n      (arst_n),
	.tx_data     (tx_data),
	.tx_valid    (tx_valid),
	.tx_ready    (tx_ready),
	.sout        (sout),
	.rx_data     (rx_data),
	.rx_valid    (rx_valid),
	.rx_ready    (rx_ready),
	.rx_done     (rx_done)
);

// File: testbench/uart_subsys_tb.sv
`timescale 1ns/10ps

module uart_subsys_tb;
	import uart_cfg_pkg::*;
	import uart_stat_pkg::*;

	localparam int NUM_REC    = 12;
	localparam int NUM_FIELDS = 10;
	// column offsets inside one golden record
	localparam int F_LEN   = 0;
	localparam int F_TWO   = 1;
	localparam int F_PAR   = 2;
	localparam int F_EVEN  = 3;
	localparam int F_DIV   = 4;
	localparam int F_BYTE  = 5;
	localparam int F_FAULT = 6;
	localparam int F_HOLD  = 7;
	localparam int F_EXP_D = 8;
	localparam int F_EXP_E = 9;
	localparam int FAULT_PAR   = 1;
	localparam int FAULT_STOP1 = 2;
	localparam int FAULT_STOP2 = 3;

	logic        test_tx_clk;
	logic        arst_n;
	uart_len_t   data_len;
	logic        two_stop;
	logic        parity_en;
	logic        even_parity;
	uart_div_t   divisor;
	uart_data_t  tx_data;
	logic        tx_valid;
	logic        tx_ready;
	logic        sout;
	logic        sin;
	uart_data_t  rx_data;
	uart_err_t   rx_err;
	logic        rx_valid;
	logic        rx_ready;
	logic        stats_clear;
	uart_count_t tx_count;
	uart_count_t rx_count;
	uart_count_t par_err_count;
	uart_count_t stop_err_count;
	uart_count_t overrun_count;

	logic [15:0] gold [NUM_REC*NUM_FIELDS];
	int          errors = 0;
	int          cycles = 0;
	int          cycle_limit = 0;
	int          bit_clks;
	string       phase;

	uart_subsys_top uart_subsys_top_i (.*);

	initial test_tx_clk = 1'b0;
	always #2 test_tx_clk = ~test_tx_clk;

	// watchdog
	always @(posedge test_tx_clk)
	begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("timeout after %0d cycles, the DUT stopped responding", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic int field_of(input int rec, input int f);
		return int'(gold[rec*NUM_FIELDS + f]);
	endfunction

	// low bits kept for a character of selector+5 bits
	function automatic int char_mask(input int rec);
		return 32'hff >> (3 - field_of(rec, F_LEN));
	endfunction

	// xor of the data bits for even, inverted for odd
	function automatic logic line_parity(input int rec, input int data);
		logic p;
		p = ^(data & char_mask(rec));
		return field_of(rec, F_EVEN) ? p : ~p;
	endfunction

	task automatic report_mismatch(input string name, input int got, input int exp);
		$display("[FAIL] %s %s: got 0x%0h, expected 0x%0h", phase, name, got, exp);
		errors++;
	endtask

	task automatic apply_config(input int rec);
		@(posedge test_tx_clk);
		data_len    <= uart_len_t'(field_of(rec, F_LEN));
		two_stop    <= field_of(rec, F_TWO) != 0;
		parity_en   <= field_of(rec, F_PAR) != 0;
		even_parity <= field_of(rec, F_EVEN) != 0;
		divisor     <= uart_div_t'(field_of(rec, F_DIV));
		bit_clks = 16 * (field_of(rec, F_DIV) + 1);
		// baud counter reloads with the new divisor
		repeat (8) @(posedge test_tx_clk);
	endtask

	//////////////////////////////
	// transmit side
	//////////////////////////////
	task automatic send_and_check_tx(input int rec);
		int   i;
		int   got;
		int   len;
		logic par_bit;
		got = 0;
		len = field_of(rec, F_LEN) + 5;
		par_bit = line_parity(rec, field_of(rec, F_BYTE));
		@(posedge test_tx_clk);
		tx_data  <= uart_data_t'(field_of(rec, F_BYTE));
		tx_valid <= 1'b1;
		@(negedge test_tx_clk);
		while (!tx_ready)
			@(negedge test_tx_clk);
		@(posedge test_tx_clk);
		tx_valid <= 1'b0;
		// start bit edge, then mid-bit samples
		@(negedge test_tx_clk);
		while (sout)
			@(negedge test_tx_clk);
		repeat (bit_clks / 2) @(negedge test_tx_clk);
		if (sout !== 1'b0)
			report_mismatch("sout start bit", sout, 0);
		for (i = 0; i < len; i++)
		begin
			repeat (bit_clks) @(negedge test_tx_clk);
			got = got | (int'(sout) << i);
		end
		if (got != (field_of(rec, F_BYTE) & char_mask(rec)))
			report_mismatch("sout data", got, field_of(rec, F_BYTE) & char_mask(rec));
		if (field_of(rec, F_PAR) != 0)
		begin
			repeat (bit_clks) @(negedge test_tx_clk);
			if (sout !== par_bit)
				report_mismatch("sout parity bit", sout, par_bit);
		end
		for (i = 0; i < 1 + field_of(rec, F_TWO); i++)
		begin
			repeat (bit_clks) @(negedge test_tx_clk);
			if (sout !== 1'b1)
				report_mismatch("sout stop bit", sout, 1);
		end
		while (!tx_ready)
			@(negedge test_tx_clk);
	endtask

	//////////////////////////////
	// receive side
	//////////////////////////////
	task automatic drive_frame(input int rec, input int nth);
		logic [12:0] bits;
		uart_data_t  byte_v;
		logic        par_bit;
		int          nbits;
		int          fault;
		int          i;
		byte_v = uart_data_t'(field_of(rec, F_BYTE));
		// later frames carry the inverted byte
		if (nth > 0)
			byte_v = ~byte_v;
		par_bit = line_parity(rec, int'(byte_v));
		fault  = field_of(rec, F_FAULT);
		bits    = '1;
		bits[0] = 1'b0;
		nbits   = 1 + field_of(rec, F_LEN) + 5;
		for (i = 1; i < nbits; i++)
			bits[i] = byte_v[i-1];
		if (field_of(rec, F_PAR) != 0)
		begin
			bits[nbits] = (fault == FAULT_PAR) ? ~par_bit : par_bit;
			nbits++;
		end
		bits[nbits] = (fault == FAULT_STOP1) ? 1'b0 : 1'b1;
		nbits++;
		// with one stop bit there is no slot for the stop2 fault
		if (field_of(rec, F_TWO) != 0)
		begin
			bits[nbits] = (fault == FAULT_STOP2) ? 1'b0 : 1'b1;
			nbits++;
		end
		// one idle bit after the frame
		nbits++;
		for (i = 0; i < nbits; i++)
		begin
			@(posedge test_tx_clk);
			sin <= bits[i];
			repeat (bit_clks - 1) @(posedge test_tx_clk);
		end
	endtask

	task automatic accept_rx(input int rec);
		@(negedge test_tx_clk);
		while (!rx_valid)
			@(negedge test_tx_clk);
		if (rx_data !== uart_data_t'(field_of(rec, F_EXP_D)))
			report_mismatch("rx_data", rx_data, field_of(rec, F_EXP_D));
		if (rx_err !== uart_err_t'(field_of(rec, F_EXP_E)))
			report_mismatch("rx_err", rx_err, field_of(rec, F_EXP_E));
		@(posedge test_tx_clk);
		rx_ready <= 1'b1;
		@(posedge test_tx_clk);
		rx_ready <= 1'b0;
	endtask

	initial
	begin
		int rec;
		int hold;
		int frm;
		int test_errs;
		int tests_failed;
		int ovr_before;
		int exp_par;
		int exp_stop;
		int exp_ovr;
		tests_failed = 0;
		exp_par      = 0;
		exp_stop     = 0;
		exp_ovr      = 0;
		arst_n      = 1'b0;
		data_len    = '0;
		two_stop    = 1'b0;
		parity_en   = 1'b0;
		even_parity = 1'b0;
		divisor     = '0;
		tx_data     = '0;
		tx_valid    = 1'b0;
		sin         = 1'b1;
		rx_ready    = 1'b0;
		stats_clear = 1'b0;
		$readmemh("testbench/uart_golden.hex", gold);
		// two 13-bit frames per record at its own bit rate
		cycle_limit = 200;
		for (rec = 0; rec < NUM_REC; rec++)
			cycle_limit += 2 * 13 * 16 * (field_of(rec, F_DIV) + 1);
		repeat (3) @(posedge test_tx_clk);
		arst_n <= 1'b1;

		for (rec = 0; rec < NUM_REC; rec++)
		begin
			phase      = $sformatf("test %0d", rec);
			test_errs  = errors;
			hold       = field_of(rec, F_HOLD);
			ovr_before = int'(overrun_count);
			apply_config(rec);
			fork
				send_and_check_tx(rec);
				for (frm = 0; frm < hold; frm++)
					drive_frame(rec, frm);
			join
			accept_rx(rec);
			@(negedge test_tx_clk);
			if (int'(overrun_count) != ovr_before + hold - 1)
				report_mismatch("overrun_count", overrun_count, ovr_before + hold - 1);
			// totals from the file's expected flags
			exp_par  += (field_of(rec, F_EXP_E) & 1) != 0;
			exp_stop += (field_of(rec, F_EXP_E) & 6) != 0;
			exp_ovr  += hold - 1;
			if (errors != test_errs)
				tests_failed++;
			$display("test %0d: %s", rec, (errors == test_errs) ? "ok" : "mismatch");
		end

		//////////////////////////////
		// counter totals and clear
		//////////////////////////////
		phase = "end of run";
		test_errs = errors;
		if (int'(tx_count) != NUM_REC)
			report_mismatch("tx_count", tx_count, NUM_REC);
		if (int'(rx_count) != NUM_REC)
			report_mismatch("rx_count", rx_count, NUM_REC);
		if (int'(par_err_count) != exp_par)
			report_mismatch("par_err_count", par_err_count, exp_par);
		if (int'(stop_err_count) != exp_stop)
			report_mismatch("stop_err_count", stop_err_count, exp_stop);
		if (int'(overrun_count) != exp_ovr)
			report_mismatch("overrun_count", overrun_count, exp_ovr);
		@(posedge test_tx_clk);
		stats_clear <= 1'b1;
		@(posedge test_tx_clk);
		stats_clear <= 1'b0;
		@(negedge test_tx_clk);
		phase = "after stats_clear";
		if (tx_count !== '0)
			report_mismatch("tx_count", tx_count, 0);
		if (rx_count !== '0)
			report_mismatch("rx_count", rx_count, 0);
		if (par_err_count !== '0)
			report_mismatch("par_err_count", par_err_count, 0);
		if (stop_err_count !== '0)
			report_mismatch("stop_err_count", stop_err_count, 0);
		if (overrun_count !== '0)
			report_mismatch("overrun_count", overrun_count, 0);
		if (errors != test_errs)
			tests_failed++;
		$display("counters: %s", (errors == test_errs) ? "ok" : "mismatch");

		$display("%0d tests run, %0d with mismatches, %0d mismatches in total",
			NUM_REC + 1, tests_failed, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: testbench/uart_golden.hex
// len two_stop parity_en even_parity divisor byte fault hold exp_rx_data exp_rx_err
// fault 0 none, 1 parity flip, 2 stop1 low, 3 stop2 low; hold is frames sent before rx_ready
// clean frames over lengths, parity and stop settings
3 0 0 0 0001 a5 0 1 a5 0
3 0 1 1 0001 3c 0 1 3c 0
3 1 1 0 0002 c3 0 1 c3 0
0 0 0 0 0000 ff 0 1 1f 0
1 1 0 0 0001 6d 0 1 2d 0
2 0 1 0 0003 9a 0 1 1a 0
// injected faults
3 0 1 1 0001 81 1 1 81 1
3 0 0 0 0001 5a 2 1 5a 2
2 1 1 1 0002 47 3 1 47 4
3 0 1 0 0001 e7 3 1 e7 0
// rx_ready held off for two frames
3 0 0 0 0001 12 0 2 12 0
1 1 1 1 0000 b4 2 2 34 2

// File: sources.f
src/uart_cfg_pkg.sv
src/uart_stat_pkg.sv
src/uart_baud_gen.sv
src/uart_tx_frame.sv
src/uart_rx_frame.sv
src/uart_line_stats.sv
src/uart_subsys_top.sv
testbench/uart_subsys_chk.sv
testbench/uart_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the UART subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module uart_subsys_tb -f sources.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vuart_subsys_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qxF '>>> PASS'; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
